// ==== Bender.yml ====
package:
  name: frame_tx

sources:
  - files:
      - common/tx_pkg.sv
      - common/tx_ctrl_if.sv
      - hw/mux_n_to_1.sv
      - hw/bit_timer.sv
      - hw/payload_reg.sv
      - hw/tx_fsm.sv
      - hw/frame_tx_top.sv
  - target: test
    files:
      - sim/frame_tx_tb.sv

// ==== common/tx_ctrl_if.sv ====
`timescale 1ns/10ps

interface tx_ctrl_if;

    logic                     run;
    logic                     clear;
    logic                     bit_end;  // Last clock of the current bit period.
    logic                     last_bit;
    logic [tx_pkg::SEL_W-1:0] bit_idx;

    modport fsm (
        output run,
        output clear,
        input  bit_end,
        input  last_bit,
        input  bit_idx
    );

    modport timer (
        input  run,
        input  clear,
        output bit_end,
        output last_bit,
        output bit_idx
    );

endinterface

// ==== common/tx_pkg.sv ====
package tx_pkg;

    localparam int DATA_W = 8;
    localparam int FRAME_W = DATA_W + 1; // Data bits plus the parity bit.
    localparam int SEL_W = 4;
    localparam int CLKS_PER_BIT = 4;
    localparam int CNT_W = $clog2(CLKS_PER_BIT);

    localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(CLKS_PER_BIT - 1);
    localparam logic [SEL_W-1:0] LAST_IDX = SEL_W'(FRAME_W - 1);

    // Frame phases as seen on the line.
    typedef enum logic [1:0] {
        IDLE,
        START,
        PAYLOAD,
        STOP
    } tx_state_e;

endpackage

// ==== hw/bit_timer.sv ====
`timescale 1ns/10ps

module bit_timer (
    input  logic     clk,
    input  logic     rst,
    tx_ctrl_if.timer ctrl,
    input  logic     advance
);

    logic [tx_pkg::CNT_W-1:0] clk_cnt;
    logic [tx_pkg::SEL_W-1:0] bit_idx;

    assign ctrl.bit_end  = ctrl.run && (clk_cnt == tx_pkg::LAST_CNT);
    assign ctrl.last_bit = (bit_idx == tx_pkg::LAST_IDX);
    assign ctrl.bit_idx  = bit_idx;

    always_ff @(posedge clk) begin
        if (rst || ctrl.clear) begin
            clk_cnt <= '0;
            bit_idx <= '0;
        end else if (ctrl.run) begin
            if (ctrl.bit_end) begin
                clk_cnt <= '0;
                if (advance) begin
                    // Wrap after the parity bit so the next frame starts at bit 0.
                    bit_idx <= ctrl.last_bit ? '0 : bit_idx + 1'b1;
                end
            end else begin
                clk_cnt <= clk_cnt + 1'b1;
            end
        end
    end

    a_idx_range: assert property (
        @(posedge clk) disable iff (rst)
        bit_idx < tx_pkg::FRAME_W
    );

endmodule

// ==== hw/frame_tx_top.sv ====
`timescale 1ns/10ps

module frame_tx_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      start,
    input  logic [tx_pkg::DATA_W-1:0] data,
    output logic                      sdo,
    output logic                      busy,
    output logic                      done
);

    logic load;
    logic advance;
    logic pay_bit;

    tx_ctrl_if ctrl_if ();

    tx_fsm u_fsm (
        .clk    (clk),
        .rst    (rst),
        .start  (start),
        .ctrl   (ctrl_if.fsm),
        .pay_bit(pay_bit),
        .load   (load),
        .advance(advance),
        .sdo    (sdo),
        .busy   (busy),
        .done   (done)
    );

    bit_timer u_timer (
        .clk    (clk),
        .rst    (rst),
        .ctrl   (ctrl_if.timer),
        .advance(advance)
    );

    payload_reg u_payload (
        .clk    (clk),
        .rst    (rst),
        .load   (load),
        .data   (data),
        .bit_idx(ctrl_if.bit_idx),
        .pay_bit(pay_bit)
    );

endmodule

// ==== hw/mux_n_to_1.sv ====
`timescale 1ns/10ps

module mux_n_to_1 #(
    parameter int N = 9,
    parameter int m = 4
) (
    input  logic [N-1:0] inp,
    input  logic [m-1:0] select,
    output logic         out
);

    generate
        if (N == 1) begin : g_leaf
            assign out = inp[0];
        end else if (N == 2) begin : g_pair
            assign out = select[0] ? inp[1] : inp[0];
        end else if (N <= 2 ** (m - 1)) begin : g_narrow
            // The top select bit is always low for a valid index here.
            mux_n_to_1 #(
                .N(N),
                .m(m - 1)
            ) u_sub (
                .inp   (inp),
                .select(select[m-2:0]),
                .out   (out)
            );
        end else begin : g_split
            logic lo_out;
            logic hi_out;

            mux_n_to_1 #(
                .N(2 ** (m - 1)),
                .m(m - 1)
            ) u_lo (
                .inp   (inp[2**(m-1)-1:0]),
                .select(select[m-2:0]),
                .out   (lo_out)
            );

            // Upper part holds whatever is left above the power of two.
            mux_n_to_1 #(
                .N(N - 2 ** (m - 1)),
                .m(m - 1)
            ) u_hi (
                .inp   (inp[N-1:2**(m-1)]),
                .select(select[m-2:0]),
                .out   (hi_out)
            );

            assign out = select[m-1] ? hi_out : lo_out;
        end
    endgenerate

endmodule

// ==== hw/payload_reg.sv ====
`timescale 1ns/10ps

module payload_reg (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      load,
    input  logic [tx_pkg::DATA_W-1:0] data,
    input  logic [tx_pkg::SEL_W-1:0]  bit_idx,
    output logic                      pay_bit
);

    logic [tx_pkg::FRAME_W-1:0] payload;
    logic                       parity;

    assign parity = ^data; // Even parity over the data byte.

    always_ff @(posedge clk) begin
        if (rst) begin
            payload <= '0;
        end else if (load) begin
            payload <= {parity, data}; // Parity goes out last.
        end
    end

    mux_n_to_1 #(
        .N(tx_pkg::FRAME_W),
        .m(tx_pkg::SEL_W)
    ) u_mux (
        .inp   (payload),
        .select(bit_idx),
        .out   (pay_bit)
    );

endmodule

// ==== hw/tx_fsm.sv ====
`timescale 1ns/10ps

module tx_fsm (
    input  logic   clk,
    input  logic   rst,
    input  logic   start,
    tx_ctrl_if.fsm ctrl,
    input  logic   pay_bit,
    output logic   load,
    output logic   advance,
    output logic   sdo,
    output logic   busy,
    output logic   done
);

    tx_pkg::tx_state_e state;
    tx_pkg::tx_state_e state_next;

    assign load    = (state == tx_pkg::IDLE) && start; // Starts are ignored outside IDLE.
    assign advance = (state == tx_pkg::PAYLOAD);

    always_comb begin
        state_next = state;
        case (state)
            tx_pkg::IDLE: begin
                if (start) begin
                    state_next = tx_pkg::START;
                end
            end
            tx_pkg::START: begin
                if (ctrl.bit_end) begin
                    state_next = tx_pkg::PAYLOAD;
                end
            end
            tx_pkg::PAYLOAD: begin
                if (ctrl.bit_end && ctrl.last_bit) begin
                    state_next = tx_pkg::STOP;
                end
            end
            tx_pkg::STOP: begin
                if (ctrl.bit_end) begin
                    state_next = tx_pkg::IDLE;
                end
            end
            default: state_next = tx_pkg::IDLE;
        endcase
    end

    // The line, busy and done trail the state by one clock.
    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= tx_pkg::IDLE;
            sdo        <= 1'b1;
            busy       <= 1'b0;
            done       <= 1'b0;
            ctrl.run   <= 1'b0;
            ctrl.clear <= 1'b0;
        end else begin
            state      <= state_next;
            ctrl.run   <= (state_next != tx_pkg::IDLE);
            ctrl.clear <= (state == tx_pkg::STOP) && ctrl.bit_end; // Resync the timer.
            busy       <= (state != tx_pkg::IDLE);
            done       <= busy && (state == tx_pkg::IDLE); // Busy is falling.
            case (state)
                tx_pkg::START:   sdo <= 1'b0;
                tx_pkg::PAYLOAD: sdo <= pay_bit;
                default:         sdo <= 1'b1;
            endcase
        end
    end

    a_done_pulse: assert property (
        @(posedge clk) disable iff (rst)
        done |=> !done
    );

    a_done_not_busy: assert property (
        @(posedge clk) disable iff (rst)
        !(done && busy)
    );

endmodule

// ==== sim/frame_trace.txt ====
// data (hex), idle clocks after done before the next request,
// extra start strobe during the frame (0/1), expected even parity bit
a5 3 0 0
00 0 0 0
ff 0 1 0
01 5 0 1
80 0 0 1
3c 2 1 0
13 0 0 1
7e 0 1 0
c3 4 0 0
5b 0 0 1
07 1 1 1
96 0 0 0
2c 0 1 1
f1 6 0 1
d6 0 0 1
55 2 0 0

// ==== sim/frame_tx_tb.sv ====
`timescale 1ns/10ps

module frame_tx_tb;

    logic                      clk;
    logic                      rst;
    logic                      start;
    logic [tx_pkg::DATA_W-1:0] data;
    logic                      sdo;
    logic                      busy;
    logic                      done;

    logic [tx_pkg::DATA_W-1:0] trace_byte[$];
    int                        trace_gap[$];
    int                        trace_extra[$];
    logic                      trace_par[$];

    frame_tx_top DUT (
        .clk  (clk),
        .rst  (rst),
        .start(start),
        .data (data),
        .sdo  (sdo),
        .busy (busy),
        .done (done)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic abort_run();
        $display("ERRORS FOUND");
        $fatal(1, "Run stopped at the first failure.");
    endtask

    task automatic check_line(string name, logic expected, logic actual);
        if (actual !== expected) begin
            $display("error at %0t: %s expected %b, actual %b", $time, name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_byte(string name, logic [tx_pkg::DATA_W-1:0] expected,
                              logic [tx_pkg::DATA_W-1:0] actual);
        if (actual !== expected) begin
            $display("error at %0t: %s expected %h, actual %h", $time, name, expected, actual);
            abort_run();
        end
    endtask

    // Outputs are registered, so they are settled 2 ns after the edge.
    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic check_idle();
        check_line("sdo", 1'b1, sdo);
        check_line("busy", 1'b0, busy);
        check_line("done", 1'b0, done);
    endtask

    function automatic logic even_parity(logic [tx_pkg::DATA_W-1:0] value);
        logic acc;
        acc = 1'b0;
        for (int i = 0; i < tx_pkg::DATA_W; i++) begin
            acc = acc ^ value[i];
        end
        return acc;
    endfunction

    task automatic read_trace();
        int                        fd;
        int                        n;
        string                     text;
        logic [tx_pkg::DATA_W-1:0] value;
        int                        gap;
        int                        extra;
        int                        par;
        fd = $fopen("sim/frame_trace.txt", "r");
        if (fd == 0) begin
            $display("The trace file sim/frame_trace.txt could not be opened.");
            abort_run();
        end
        while ($fgets(text, fd) != 0) begin
            if (text.len() < 2 || text.substr(0, 1) == "//") begin
                continue;
            end
            n = $sscanf(text, "%h %d %d %d", value, gap, extra, par);
            if (n != 4) begin
                $display("A trace line could not be parsed: %s", text);
                abort_run();
            end
            trace_byte.push_back(value);
            trace_gap.push_back(gap);
            trace_extra.push_back(extra);
            trace_par.push_back(par[0]);
        end
        $fclose(fd);
    endtask

    task automatic send_frame(logic [tx_pkg::DATA_W-1:0] value, int extra);
        logic                      line_bits[11];
        logic [tx_pkg::DATA_W-1:0] rebuilt;
        int                        count;
        start = 1'b1;
        data  = value;
        next_cycle();
        start = 1'b0;
        data  = ~value; // A stray second load would show up as a wrong byte.
        count = 0;
        while (busy !== 1'b1) begin
            check_line("done", 1'b0, done);
            if (count >= 20) begin
                $display("Timeout: busy did not rise within 20 cycles of the start strobe.");
                abort_run();
            end
            next_cycle();
            count++;
        end
        count = 0;
        while (busy === 1'b1) begin
            check_line("done", 1'b0, done);
            if (count % tx_pkg::CLKS_PER_BIT == tx_pkg::CLKS_PER_BIT / 2 &&
                count / tx_pkg::CLKS_PER_BIT < 11) begin
                line_bits[count / tx_pkg::CLKS_PER_BIT] = sdo; // Middle of the bit.
            end
            start = (extra != 0) && (count == 18); // Lands inside the payload.
            if (count >= 11 * tx_pkg::CLKS_PER_BIT + 20) begin
                $display("Timeout: busy did not fall within %0d cycles.", count);
                abort_run();
            end
            next_cycle();
            count++;
        end
        start = 1'b0;
        if (count != 11 * tx_pkg::CLKS_PER_BIT) begin
            $display("error at %0t: busy cycles expected %0d, actual %0d",
                     $time, 11 * tx_pkg::CLKS_PER_BIT, count);
            abort_run();
        end
        check_line("done", 1'b1, done);
        check_line("sdo", 1'b1, sdo);
        check_line("start bit", 1'b0, line_bits[0]);
        for (int i = 0; i < tx_pkg::DATA_W; i++) begin
            rebuilt[i] = line_bits[i + 1];
        end
        check_byte("data from sdo", value, rebuilt);
        check_line("parity bit", even_parity(value), line_bits[9]);
        check_line("stop bit", 1'b1, line_bits[10]);
    endtask

    initial begin
        rst   = 1'b1;
        start = 1'b0;
        data  = '0;
        read_trace();
        if (trace_byte.size() == 0) begin
            $display("The trace file holds no frame requests.");
            abort_run();
        end
        repeat (16) begin
            next_cycle();
            check_idle();
        end
        rst = 1'b0;
        repeat (3) begin
            next_cycle();
            check_idle();
        end
        foreach (trace_byte[i]) begin
            check_line("trace parity", even_parity(trace_byte[i]), trace_par[i]);
            send_frame(trace_byte[i], trace_extra[i]);
            repeat (trace_gap[i]) begin
                next_cycle();
                check_idle();
            end
        end
        repeat (4) begin
            next_cycle();
            check_idle();
        end
        $display("NO ERRORS");
        $finish;
    end

endmodule

// ==== verilog.f ====
common/tx_pkg.sv
common/tx_ctrl_if.sv
hw/mux_n_to_1.sv
hw/bit_timer.sv
hw/payload_reg.sv
hw/tx_fsm.sv
hw/frame_tx_top.sv
sim/frame_tx_tb.sv
